/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_muldiv
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/muldiv_ref_model.svh */
`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

function automatic logic [63:0] sext_word(input logic [31:0] v);
	return {{32{v[31]}}, v};
endfunction

// Expected RV64M result derived from the ISA rules.
function automatic logic [63:0] ref_result(
	input logic [3:0]  op,
	input logic [63:0] a,
	input logic [63:0] b
);
	logic signed [127:0] sa_wide;
	logic signed [127:0] sb_wide;
	logic signed [127:0] prod;
	logic signed [63:0]  sa;
	logic signed [63:0]  sb;
	logic signed [63:0]  q;
	logic signed [31:0]  wa;
	logic signed [31:0]  wb;
	logic signed [31:0]  wq;
	logic [31:0]         wlow;
	logic                ovf;
	logic                wovf;

	sa      = a;
	sb      = b;
	wa      = a[31:0];
	wb      = b[31:0];
	sa_wide = {{64{a[63]}}, a};
	sb_wide = {{64{b[63]}}, b};
	ovf     = (a == 64'h8000_0000_0000_0000) && (b == 64'hffff_ffff_ffff_ffff);
	wovf    = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
	case (op)
		OP_MUL: return a * b;
		OP_MULH: begin
			prod = sa_wide * sb_wide;
			return prod[127:64];
		end
		OP_MULHSU: begin
			prod = sa_wide * $signed({64'b0, b}); // Second operand unsigned.
			return prod[127:64];
		end
		OP_MULHU: begin
			prod = {64'b0, a} * {64'b0, b};
			return prod[127:64];
		end
		OP_MULW: begin
			wlow = a[31:0] * b[31:0];
			return sext_word(wlow);
		end
		OP_DIV: begin
			if (b == 64'd0) return '1;
			if (ovf) return a;
			q = sa / sb;
			return q;
		end
		OP_DIVU: return (b == 64'd0) ? '1 : a / b;
		OP_REM: begin
			if (b == 64'd0) return a;
			if (ovf) return 64'd0;
			q = sa % sb; // Sign of the dividend.
			return q;
		end
		OP_REMU: return (b == 64'd0) ? a : a % b;
		OP_DIVW: begin
			if (wb == 32'sd0) return '1;
			if (wovf) return sext_word(wa);
			wq = wa / wb;
			return sext_word(wq);
		end
		OP_DIVUW: begin
			if (b[31:0] == 32'd0) return '1;
			wlow = a[31:0] / b[31:0];
			return sext_word(wlow);
		end
		OP_REMW: begin
			if (wb == 32'sd0) return sext_word(wa);
			if (wovf) return 64'd0;
			wq = wa % wb;
			return sext_word(wq);
		end
		OP_REMUW: begin
			if (b[31:0] == 32'd0) return sext_word(a[31:0]);
			wlow = a[31:0] % b[31:0];
			return sext_word(wlow);
		end
		default: return 64'd0;
	endcase
endfunction

`endif

/* sim/tb_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv;
	import muldiv_pkg::*;

	`include "muldiv_ref_model.svh"

	localparam int CYC             = 100; // ns
	localparam int DIV_STEPS       = XLEN;
	localparam int N_RAND          = 120;
	localparam int N_DIRECTED      = 45;
	localparam int N_OPS           = N_RAND + N_DIRECTED;
	localparam int WATCHDOG_CYCLES = N_OPS * 80 + 400;

	logic              CLK = 1'b0;
	logic              arst_n;
	logic              flush;
	logic              issue_valid;
	logic              issue_ready;
	logic [OP_W-1:0]   issue_op;
	logic [REG_AW-1:0] issue_rs1;
	logic [REG_AW-1:0] issue_rs2;
	logic [REG_AW-1:0] issue_rd;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;
	logic              pre_we;
	logic [REG_AW-1:0] pre_addr;
	logic [XLEN-1:0]   pre_data;

	logic [XLEN-1:0]   mirror [0:(1<<REG_AW)-1]; // Expected register contents.
	logic [REG_AW-1:0] exp_rd_q [$];
	logic [XLEN-1:0]   exp_data_q [$];
	logic              exp_div_q [$];
	logic              div_open;  // Divide result still outstanding.
	logic              ready_due; // issue_ready must be high next cycle.
	int                seed;

	muldiv_top muldiv_top_i (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
		.issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_rd(issue_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.pre_we(pre_we), .pre_addr(pre_addr), .pre_data(pre_data)
	);

	always #(CYC/2) CLK = ~CLK;

	// ####################################################################
	// Helpers.
	// ####################################################################

	function automatic logic is_div_op(input logic [OP_W-1:0] op);
		return (op >= OP_DIV && op <= OP_REMU) || (op >= OP_DIVW && op <= OP_REMUW);
	endfunction

	function automatic logic rd_pending(input logic [REG_AW-1:0] r);
		foreach (exp_rd_q[i]) begin
			if (exp_rd_q[i] == r) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic logic [REG_AW-1:0] pick_src();
		int r;
		r = $random(seed);
		return REG_AW'(1 + (r & 32'h7fff_ffff) % 31);
	endfunction

	// x0 or x7..x31 to keep the boundary values in x1..x6.
	function automatic logic [REG_AW-1:0] pick_dst();
		int r;
		r = $random(seed);
		r = (r & 32'h7fff_ffff) % 26;
		return (r == 0) ? '0 : REG_AW'(r + 6);
	endfunction

	function automatic logic [XLEN-1:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	task automatic stop_on_error(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic preload(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
		pre_we   = 1'b1;
		pre_addr = addr;
		pre_data = data;
		@(posedge CLK);
		#1;
		pre_we   = 1'b0;
	endtask

	// Issue one operation and hold it until the handshake completes.
	task automatic send(
		input logic [OP_W-1:0]   op,
		input logic [REG_AW-1:0] rs1,
		input logic [REG_AW-1:0] rs2,
		input logic [REG_AW-1:0] rd
	);
		while (rd_pending(rs1) || rd_pending(rs2)) begin
			@(posedge CLK); // No forwarding in the DUT.
			#1;
		end
		issue_valid = 1'b1;
		issue_op    = op;
		issue_rs1   = rs1;
		issue_rs2   = rs2;
		issue_rd    = rd;
		do begin
			@(negedge CLK);
		end while (!issue_ready);
		@(posedge CLK);
		#1;
		issue_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_rd_q.size() != 0) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// ####################################################################
	// Scoreboard sampled mid-cycle.
	// ####################################################################

	always @(negedge CLK) begin : scoreboard
		logic [XLEN-1:0] exp_val;
		if (!arst_n) begin
			foreach (mirror[i]) begin
				mirror[i] = '0;
			end
			div_open  = 1'b0;
			ready_due = 1'b0;
		end else begin
			if (ready_due) begin
				assert (issue_ready)
				else stop_on_error("issue_ready still low one cycle after divide result or flush");
				ready_due = 1'b0;
			end
			if (div_open) begin
				assert (!issue_ready) else stop_on_error("issue_ready high during a divide");
			end
			if (pre_we && pre_addr != '0) begin
				mirror[pre_addr] = pre_data;
			end
			if (wb_valid) begin
				assert (exp_rd_q.size() != 0) else stop_on_error("writeback with nothing issued");
				assert (wb_rd == exp_rd_q[0])
				else stop_on_error($sformatf("wb_rd is %0d, expected %0d", wb_rd, exp_rd_q[0]));
				assert (wb_data == exp_data_q[0])
				else stop_on_error($sformatf("wb_data for x%0d is %h, expected %h",
					wb_rd, wb_data, exp_data_q[0]));
				if (exp_rd_q[0] != '0) begin
					mirror[exp_rd_q[0]] = exp_data_q[0];
				end
				if (exp_div_q[0]) begin
					div_open  = 1'b0;
					ready_due = 1'b1;
				end
				void'(exp_rd_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_div_q.pop_front());
			end
			if (flush) begin
				exp_rd_q.delete(); // Nothing in flight survives.
				exp_data_q.delete();
				exp_div_q.delete();
				div_open  = 1'b0;
				ready_due = 1'b1;
			end else if (issue_valid && issue_ready && issue_op <= OP_REMUW) begin
				exp_val = ref_result(issue_op, mirror[issue_rs1], mirror[issue_rs2]);
				exp_rd_q.push_back(issue_rd);
				exp_data_q.push_back(exp_val);
				exp_div_q.push_back(is_div_op(issue_op));
				if (is_div_op(issue_op)) begin
					div_open = 1'b1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CYC);
		$display("Timeout: the operations did not all complete in time");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	// ####################################################################
	// Stimulus.
	// ####################################################################

	initial begin
		logic [OP_W-1:0]   op_r;
		logic [REG_AW-1:0] rs1_r;
		logic [REG_AW-1:0] rs2_r;
		logic [REG_AW-1:0] rd_r;
		seed        = 83;
		arst_n      = 1'b0;
		flush       = 1'b0;
		issue_valid = 1'b0;
		issue_op    = '0;
		issue_rs1   = '0;
		issue_rs2   = '0;
		issue_rd    = '0;
		pre_we      = 1'b0;
		pre_addr    = '0;
		pre_data    = '0;
		repeat (16) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		@(negedge CLK);
		assert (issue_ready && !wb_valid) else stop_on_error("DUT not idle after reset");
		@(posedge CLK);
		#1;

		// Sign boundary operands with x3 left at zero.
		preload(1, 64'h8000_0000_0000_0000);
		preload(2, 64'hffff_ffff_ffff_ffff);
		preload(4, 64'h7fff_ffff_ffff_ffff);
		preload(5, 64'hffff_ffff_8000_0000);
		preload(6, 64'h0000_0000_ffff_ffff);
		for (int r = 7; r < 32; r++) begin
			preload(REG_AW'(r), rand_word());
		end

		for (int m = 0; m <= OP_REMUW; m++) begin
			if (!is_div_op(OP_W'(m))) begin
				send(OP_W'(m), 1, 2, pick_dst()); // Back to back.
				send(OP_W'(m), 1, 4, pick_dst());
				send(OP_W'(m), 5, 6, pick_dst());
				send(OP_W'(m), 2, 4, pick_dst());
			end
		end

		for (int m = 0; m <= OP_REMUW; m++) begin
			if (is_div_op(OP_W'(m))) begin
				send(OP_W'(m), 4, 3, pick_dst()); // Divide by zero.
				send(OP_W'(m), 5, 3, pick_dst());
			end
		end
		send(OP_DIV, 1, 2, pick_dst()); // Signed overflow.
		send(OP_REM, 1, 2, pick_dst());
		send(OP_DIVW, 5, 2, pick_dst());
		send(OP_DIVW, 5, 6, pick_dst());
		send(OP_REMW, 5, 2, pick_dst());

		send(OP_MUL, 4, 4, 0);
		send(OP_MULHU, 0, 4, 7); // x0 still reads zero.

		for (int n = 0; n < N_RAND; n++) begin
			op_r  = OP_W'($random(seed));
			rs1_r = pick_src();
			rs2_r = pick_src();
			rd_r  = pick_dst();
			send(op_r, rs1_r, rs2_r, rd_r);
		end

		// Cancel a long divide part way through.
		drain();
		send(OP_DIVU, 4, 6, 15);
		repeat (5) @(posedge CLK);
		#1;
		flush = 1'b1;
		@(posedge CLK);
		#1;
		flush = 1'b0;
		repeat (DIV_STEPS + 10) @(posedge CLK);
		#1;
		send(OP_MUL, 15, 2, 16); // x15 must hold its old value.

		repeat (DIV_STEPS + 10) @(posedge CLK);
		if (exp_rd_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "results still outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+sim
src/muldiv_pkg.sv
src/muldiv_req_if.sv
src/int_regfile.sv
src/mul_unit.sv
src/div_unit.sv
src/muldiv_exec.sv
src/muldiv_top.sv
sim/tb_muldiv.sv

/* src/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
	parameter int DIV_STEPS = 64
) (
	input  logic      CLK,
	input  logic      arst_n,
	input  logic      flush,
	muldiv_req_if.div req
);
	import muldiv_pkg::*;

	localparam int CNT_W = $clog2(DIV_STEPS + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV_STEPS);
	localparam logic [XLEN-1:0] MIN_D = {1'b1, {(XLEN-1){1'b0}}};
	localparam logic [XLEN-1:0] MIN_W = {{(XLEN/2+1){1'b1}}, {(XLEN/2-1){1'b0}}};

	logic              is_w;
	logic              is_u;
	logic              is_rem;
	logic [XLEN-1:0]   a;
	logic [XLEN-1:0]   b;
	logic              a_neg;
	logic              b_neg;
	logic              dbz;
	logic              ovf;
	logic [XLEN-1:0]   spec_res;
	logic [XLEN:0]     part;
	logic              ge;
	logic [XLEN:0]     diff;
	logic [XLEN-1:0]   q_fix;
	logic [XLEN-1:0]   r_fix;

	logic              run_q;
	logic              done_q;
	logic [CNT_W-1:0]  cnt_q;
	logic [2*XLEN-1:0] rq_q;     // {remainder, quotient}.
	logic [XLEN-1:0]   dvsr_q;
	logic              q_neg_q;
	logic              r_neg_q;
	logic              w_q;
	logic              rem_q;
	logic [XLEN-1:0]   res_q;

	function automatic logic [XLEN-1:0] word_ext(input logic w, input logic [XLEN-1:0] v);
		return w ? {{(XLEN/2){v[XLEN/2-1]}}, v[XLEN/2-1:0]} : v;
	endfunction

	// ####################################################################
	// Request decode and special cases.
	// ####################################################################

	assign is_w   = (req.op == OP_DIVW) | (req.op == OP_DIVUW) | (req.op == OP_REMW)
		| (req.op == OP_REMUW);
	assign is_u   = (req.op == OP_DIVU) | (req.op == OP_REMU) | (req.op == OP_DIVUW)
		| (req.op == OP_REMUW);
	assign is_rem = (req.op == OP_REM) | (req.op == OP_REMU) | (req.op == OP_REMW)
		| (req.op == OP_REMUW);

	always_comb begin
		a = req.src1;
		b = req.src2;
		if (is_w && is_u) begin
			a = {{(XLEN/2){1'b0}}, req.src1[XLEN/2-1:0]};
			b = {{(XLEN/2){1'b0}}, req.src2[XLEN/2-1:0]};
		end else if (is_w) begin
			a = word_ext(1'b1, req.src1);
			b = word_ext(1'b1, req.src2);
		end
	end

	assign a_neg = ~is_u & a[XLEN-1];
	assign b_neg = ~is_u & b[XLEN-1];
	assign dbz   = (b == '0);
	assign ovf   = ~is_u & (&b) & (a == (is_w ? MIN_W : MIN_D));

	// Zero divisor gives all ones or the dividend and overflow gives MIN or zero.
	assign spec_res = word_ext(is_w, is_rem ? (dbz ? a : '0) : (dbz ? '1 : a));

	// ####################################################################
	// One restoring step per cycle.
	// ####################################################################

	assign part = rq_q[2*XLEN-1:XLEN-1];
	assign ge   = (part >= {1'b0, dvsr_q});
	assign diff = part - {1'b0, dvsr_q};

	assign q_fix = q_neg_q ? -rq_q[XLEN-1:0] : rq_q[XLEN-1:0];
	assign r_fix = r_neg_q ? -rq_q[2*XLEN-1:XLEN] : rq_q[2*XLEN-1:XLEN]; // Dividend sign.

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (flush) begin
				run_q <= 1'b0; // Back to idle.
			end else if (req.start_div) begin
				cnt_q <= '0;
				if (dbz || ovf) begin
					done_q <= 1'b1;
				end else begin
					run_q <= 1'b1;
				end
			end else if (run_q) begin
				if (cnt_q == LAST) begin
					run_q  <= 1'b0;
					done_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (req.start_div) begin
			rq_q    <= {{XLEN{1'b0}}, (a_neg ? -a : a)};
			dvsr_q  <= b_neg ? -b : b;
			q_neg_q <= a_neg ^ b_neg;
			r_neg_q <= a_neg;
			w_q     <= is_w;
			rem_q   <= is_rem;
			res_q   <= spec_res;
		end else if (run_q) begin
			if (cnt_q == LAST) begin
				res_q <= word_ext(w_q, rem_q ? r_fix : q_fix);
			end else begin
				rq_q <= {(ge ? diff[XLEN-1:0] : part[XLEN-1:0]), rq_q[XLEN-2:0], ge};
			end
		end
	end

	assign req.div_done   = done_q;
	assign req.div_result = res_q;
	assign req.busy       = run_q;

endmodule

`default_nettype wire

/* src/int_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module int_regfile (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic [muldiv_pkg::REG_AW-1:0] raddr_a,
	input  logic [muldiv_pkg::REG_AW-1:0] raddr_b,
	output logic [muldiv_pkg::XLEN-1:0]   rdata_a,
	output logic [muldiv_pkg::XLEN-1:0]   rdata_b,
	input  logic                          we,
	input  logic [muldiv_pkg::REG_AW-1:0] waddr,
	input  logic [muldiv_pkg::XLEN-1:0]   wdata
);
	import muldiv_pkg::*;

	localparam int NREGS = 1 << REG_AW;

	// x0 has no storage.
	logic [XLEN-1:0] regs [1:NREGS-1];

	// ####################################################################
	// Write port.
	// ####################################################################

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata; // Writes to x0 are dropped.
		end
	end

	// ####################################################################
	// Combinational read ports.
	// ####################################################################

	always_comb begin
		rdata_a = '0;
		rdata_b = '0;
		if (raddr_a != '0) begin
			rdata_a = regs[raddr_a];
		end
		if (raddr_b != '0) begin
			rdata_b = regs[raddr_b];
		end
	end

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic      CLK,
	input  logic      arst_n,
	muldiv_req_if.mul req
);
	import muldiv_pkg::*;

	logic                     is_w;
	logic                     sign1;
	logic                     sign2;
	logic [XLEN:0]            opa;
	logic [XLEN:0]            opb;
	logic signed [2*XLEN+1:0] prod;
	logic [XLEN-1:0]          res_d;

	assign is_w = (req.op == OP_MULW);

	// MULHSU keeps only the first operand signed.
	assign sign1 = ((req.op == OP_MUL) | (req.op == OP_MULH) | (req.op == OP_MULHSU))
		& req.src1[XLEN-1];
	assign sign2 = ((req.op == OP_MUL) | (req.op == OP_MULH)) & req.src2[XLEN-1];

	// 65-bit operands with the word variant sign-extending the low half.
	assign opa = is_w ? {{(XLEN/2+1){req.src1[XLEN/2-1]}}, req.src1[XLEN/2-1:0]}
		: {sign1, req.src1};
	assign opb = is_w ? {{(XLEN/2+1){req.src2[XLEN/2-1]}}, req.src2[XLEN/2-1:0]}
		: {sign2, req.src2};

	assign prod = $signed(opa) * $signed(opb);

	always_comb begin
		case (req.op)
			OP_MUL:                         res_d = prod[XLEN-1:0];
			OP_MULH, OP_MULHSU, OP_MULHU:   res_d = prod[2*XLEN-1:XLEN];
			OP_MULW:                        res_d = {{(XLEN/2){prod[XLEN/2-1]}},
				prod[XLEN/2-1:0]};
			default:                        res_d = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			req.mul_done <= 1'b0;
		end else begin
			req.mul_done <= req.start_mul; // One cycle after the strobe.
		end
	end

	always_ff @(posedge CLK) begin
		if (req.start_mul) begin
			req.mul_result <= res_d;
		end
	end

endmodule

`default_nettype wire

/* src/muldiv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_exec (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic                          flush,
	input  logic                          issue_valid,
	output logic                          issue_ready,
	input  logic [muldiv_pkg::OP_W-1:0]   issue_op,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rs1,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rs2,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rd,
	output logic [muldiv_pkg::REG_AW-1:0] rf_raddr_a,
	output logic [muldiv_pkg::REG_AW-1:0] rf_raddr_b,
	input  logic [muldiv_pkg::XLEN-1:0]   rf_rdata_a,
	input  logic [muldiv_pkg::XLEN-1:0]   rf_rdata_b,
	output logic                          rf_we,
	output logic [muldiv_pkg::REG_AW-1:0] rf_waddr,
	output logic [muldiv_pkg::XLEN-1:0]   rf_wdata,
	output logic                          wb_valid,
	output logic [muldiv_pkg::REG_AW-1:0] wb_rd,
	output logic [muldiv_pkg::XLEN-1:0]   wb_data,
	muldiv_req_if.ctrl                    req
);
	import muldiv_pkg::*;

	logic              fire;
	logic              is_mul_op;
	logic              is_div_op;
	logic              done_any;
	logic [XLEN-1:0]   done_data;
	logic              div_pend_q; // Divide accepted with its result still pending.
	logic              wb_div_q;
	logic [REG_AW-1:0] rd_q;

	always_comb begin
		is_mul_op = 1'b0;
		is_div_op = 1'b0;
		case (issue_op)
			OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW: is_mul_op = 1'b1;
			OP_DIV, OP_DIVU, OP_REM, OP_REMU,
			OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW:          is_div_op = 1'b1;
			default: ; // Unused codes vanish.
		endcase
	end

	assign issue_ready = ~flush & ~div_pend_q & ~req.busy;
	assign fire        = issue_valid & issue_ready;

	// Operands come straight from the register file.
	assign rf_raddr_a    = issue_rs1;
	assign rf_raddr_b    = issue_rs2;
	assign req.op        = issue_op;
	assign req.src1      = rf_rdata_a;
	assign req.src2      = rf_rdata_b;
	assign req.start_mul = fire & is_mul_op;
	assign req.start_div = fire & is_div_op;

	// ####################################################################
	// Writeback merge.
	// ####################################################################

	assign done_any  = req.mul_done | req.div_done; // Never both at once.
	assign done_data = req.div_done ? req.div_result : req.mul_result;

	assign rf_we    = done_any & ~flush;
	assign rf_waddr = rd_q;
	assign rf_wdata = done_data;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid   <= 1'b0;
			wb_div_q   <= 1'b0;
			div_pend_q <= 1'b0;
		end else begin
			wb_valid <= done_any & ~flush;
			wb_div_q <= req.div_done & ~flush;
			if (flush) begin
				div_pend_q <= 1'b0;
			end else if (req.start_div) begin
				div_pend_q <= 1'b1;
			end else if (wb_valid && wb_div_q) begin
				div_pend_q <= 1'b0; // Ready again after the divide's writeback.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fire) begin
			rd_q <= issue_rd;
		end
		if (done_any) begin
			wb_rd   <= rd_q;
			wb_data <= done_data;
		end
	end

endmodule

`default_nettype wire

/* src/muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

	localparam int XLEN   = 64; // One data word.
	localparam int REG_AW = 5;  // 32 integer registers.
	localparam int OP_W   = 4;

	// ####################################################################
	// RV64M operation codes.
	// ####################################################################

	localparam logic [OP_W-1:0] OP_MUL    = 4'd0;
	localparam logic [OP_W-1:0] OP_MULH   = 4'd1;
	localparam logic [OP_W-1:0] OP_MULHSU = 4'd2;
	localparam logic [OP_W-1:0] OP_MULHU  = 4'd3;

	localparam logic [OP_W-1:0] OP_DIV    = 4'd4;
	localparam logic [OP_W-1:0] OP_DIVU   = 4'd5;
	localparam logic [OP_W-1:0] OP_REM    = 4'd6;
	localparam logic [OP_W-1:0] OP_REMU   = 4'd7;

	// Word variants.
	localparam logic [OP_W-1:0] OP_MULW   = 4'd8;
	localparam logic [OP_W-1:0] OP_DIVW   = 4'd9;
	localparam logic [OP_W-1:0] OP_DIVUW  = 4'd10;
	localparam logic [OP_W-1:0] OP_REMW   = 4'd11;
	localparam logic [OP_W-1:0] OP_REMUW  = 4'd12;

	// Codes 13 to 15 are not assigned.

endpackage

`default_nettype wire

/* src/muldiv_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface muldiv_req_if;
	import muldiv_pkg::*;

	logic            start_mul;  // Single-cycle strobes.
	logic            start_div;
	logic [OP_W-1:0] op;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;

	logic            mul_done;
	logic [XLEN-1:0] mul_result;

	logic            div_done;
	logic [XLEN-1:0] div_result;
	logic            busy;       // Divider iterating.

	modport ctrl (output start_mul, start_div, op, src1, src2,
		input mul_done, mul_result, div_done, div_result, busy);
	modport mul (input start_mul, op, src1, src2, output mul_done, mul_result);
	modport div (input start_div, op, src1, src2, output div_done, div_result, busy);

endinterface

`default_nettype wire

/* src/muldiv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic                          flush,
	input  logic                          issue_valid,
	output logic                          issue_ready,
	input  logic [muldiv_pkg::OP_W-1:0]   issue_op,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rs1,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rs2,
	input  logic [muldiv_pkg::REG_AW-1:0] issue_rd,
	output logic                          wb_valid,
	output logic [muldiv_pkg::REG_AW-1:0] wb_rd,
	output logic [muldiv_pkg::XLEN-1:0]   wb_data,
	input  logic                          pre_we,
	input  logic [muldiv_pkg::REG_AW-1:0] pre_addr,
	input  logic [muldiv_pkg::XLEN-1:0]   pre_data
);
	import muldiv_pkg::*;

	wire [REG_AW-1:0] raddr_a;
	wire [REG_AW-1:0] raddr_b;
	wire [XLEN-1:0]   rdata_a;
	wire [XLEN-1:0]   rdata_b;
	wire              exec_we;
	wire [REG_AW-1:0] exec_waddr;
	wire [XLEN-1:0]   exec_wdata;

	// Execute write wins over preload.
	wire              rf_we    = exec_we | pre_we;
	wire [REG_AW-1:0] rf_waddr = exec_we ? exec_waddr : pre_addr;
	wire [XLEN-1:0]   rf_wdata = exec_we ? exec_wdata : pre_data;

	muldiv_req_if req_if ();

	int_regfile int_regfile_i (
		.CLK(CLK), .arst_n(arst_n),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	muldiv_exec muldiv_exec_i (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
		.issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_rd(issue_rd),
		.rf_raddr_a(raddr_a), .rf_raddr_b(raddr_b),
		.rf_rdata_a(rdata_a), .rf_rdata_b(rdata_b),
		.rf_we(exec_we), .rf_waddr(exec_waddr), .rf_wdata(exec_wdata),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.req(req_if.ctrl)
	);

	mul_unit mul_unit_i (.CLK(CLK), .arst_n(arst_n), .req(req_if.mul));

	div_unit #(.DIV_STEPS(XLEN)) div_unit_i (
		.CLK(CLK), .arst_n(arst_n), .flush(flush), .req(req_if.div)
	);

endmodule

`default_nettype wire
